/* mips_pkg.sv */
package mips_pkg;

	// datapath word width
	localparam int word_bits = 32;
	// first fetch address after reset
	localparam logic [word_bits-1:0] reset_pc = '0;

	// primary opcode field, instr[31:26]
	typedef enum logic [5:0] {
		op_rtype = 6'b000000,
		op_j     = 6'b000010,
		op_beq   = 6'b000100,
		op_addi  = 6'b001000,
		op_lw    = 6'b100011,
		op_sw    = 6'b101011
	} opcode_e;

	// r-type function field, instr[5:0]
	typedef enum logic [5:0] {
		fn_add = 6'b100000,
		fn_sub = 6'b100010,
		fn_and = 6'b100100,
		fn_or  = 6'b100101,
		fn_slt = 6'b101010
	} funct_e;

	// coarse alu request from the main decoder
	typedef enum logic [1:0] {
		aluop_add   = 2'b00,
		aluop_sub   = 2'b01,
		aluop_funct = 2'b10
	} aluop_e;

	// alu operation select
	typedef enum logic [2:0] {
		alu_and = 3'b000,
		alu_or  = 3'b001,
		alu_add = 3'b010,
		alu_sub = 3'b110,
		alu_slt = 3'b111
	} alu_ctrl_e;

	// next pc source
	typedef enum logic [1:0] {
		pc_from_alu    = 2'b00,
		pc_from_aluout = 2'b01,
		pc_from_jump   = 2'b10
	} pcsrc_e;

	// alu b operand source
	typedef enum logic [1:0] {
		b_reg         = 2'b00,
		b_four        = 2'b01,
		b_imm         = 2'b10,
		b_imm_shifted = 2'b11
	} alusrcb_e;

	// multicycle control states, encoded in sequence
	typedef enum logic [3:0] {
		s_fetch,
		s_decode,
		s_mem_addr,
		s_mem_read,
		s_mem_writeback,
		s_mem_write,
		s_execute,
		s_alu_writeback,
		s_branch,
		s_addi_execute,
		s_addi_writeback,
		s_jump
	} state_e;

	// control word, 15 bits, msb first
	typedef struct packed {
		logic     memwrite;
		logic     iord;
		logic     irwrite;
		logic     regdst;
		logic     memtoreg;
		logic     regwrite;
		logic     alusrca;
		alusrcb_e alusrcb;
		pcsrc_e   pcsrc;
		aluop_e   aluop;
		logic     branch;
		logic     pcwrite;
	} ctrl_t;

	// unified memory request, 65 bits
	typedef struct packed {
		logic [word_bits-1:0] addr;
		logic [word_bits-1:0] wdata;
		logic                 we;
	} mem_req_t;

endpackage

/* alu.sv */
module alu (
	input  logic [mips_pkg::word_bits-1:0] a,
	input  logic [mips_pkg::word_bits-1:0] b,
	input  mips_pkg::alu_ctrl_e            op,
	output logic [mips_pkg::word_bits-1:0] y,
	output logic                           zero
);

	logic lt;

	// signed compare for slt
	assign lt = $signed(a) < $signed(b);

	always_comb begin
		case (op)
			mips_pkg::alu_and: y = a & b;
			mips_pkg::alu_or:  y = a | b;
			mips_pkg::alu_add: y = a + b;
			mips_pkg::alu_sub: y = a - b;
			mips_pkg::alu_slt: y = {{(mips_pkg::word_bits-1){1'b0}}, lt};
			default:           y = a + b;
		endcase
	end

	// beq looks at this after a subtract
	assign zero = (y == '0);

endmodule

/* regfile.sv */
module regfile (
	input  logic                           clk,
	input  logic [4:0]                     ra1,
	input  logic [4:0]                     ra2,
	input  logic [4:0]                     wa,
	input  logic                           we,
	input  logic [mips_pkg::word_bits-1:0] wd,
	output logic [mips_pkg::word_bits-1:0] rd1,
	output logic [mips_pkg::word_bits-1:0] rd2
);

	logic [mips_pkg::word_bits-1:0] rf [32];

	// write on the edge, r0 never written
	always_ff @(posedge clk) begin
		if (we && (wa != 5'd0)) begin
			rf[wa] <= wd;
		end
	end

	// asynchronous reads, r0 hardwired to zero
	assign rd1 = (ra1 == 5'd0) ? '0 : rf[ra1];
	assign rd2 = (ra2 == 5'd0) ? '0 : rf[ra2];

	// destination must be resolved when the decoder asks for a write
	wa_known: assert property (@(posedge clk) we |-> !$isunknown(wa));

endmodule

/* main_decoder.sv */
module main_decoder (
	input  logic              clk,
	input  logic              reset,
	input  mips_pkg::opcode_e op,
	output mips_pkg::ctrl_t   ctrl,
	output mips_pkg::state_e  state
);

	mips_pkg::state_e next_state;

	// state register
	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			state <= mips_pkg::s_fetch;
		end else begin
			state <= next_state;
		end
	end

	// next state
	always_comb begin
		next_state = mips_pkg::s_fetch;
		case (state)
			mips_pkg::s_fetch: next_state = mips_pkg::s_decode;
			mips_pkg::s_decode: begin
				// branch out by instruction class
				case (op)
					mips_pkg::op_rtype: next_state = mips_pkg::s_execute;
					mips_pkg::op_lw:    next_state = mips_pkg::s_mem_addr;
					mips_pkg::op_sw:    next_state = mips_pkg::s_mem_addr;
					mips_pkg::op_beq:   next_state = mips_pkg::s_branch;
					mips_pkg::op_addi:  next_state = mips_pkg::s_addi_execute;
					mips_pkg::op_j:     next_state = mips_pkg::s_jump;
					// unknown opcode behaves as a no-op
					default:            next_state = mips_pkg::s_fetch;
				endcase
			end
			mips_pkg::s_mem_addr: begin
				// loads read, everything else here is a store
				if (op == mips_pkg::op_lw) begin
					next_state = mips_pkg::s_mem_read;
				end else begin
					next_state = mips_pkg::s_mem_write;
				end
			end
			mips_pkg::s_mem_read:     next_state = mips_pkg::s_mem_writeback;
			mips_pkg::s_execute:      next_state = mips_pkg::s_alu_writeback;
			mips_pkg::s_addi_execute: next_state = mips_pkg::s_addi_writeback;
			default:                  next_state = mips_pkg::s_fetch;
		endcase
	end

	// moore outputs, one fixed word per state
	always_comb begin
		ctrl = '0;
		case (state)
			mips_pkg::s_fetch: begin
				// read instruction at pc, pc <= pc + 4
				ctrl.irwrite = 1'b1;
				ctrl.alusrcb = mips_pkg::b_four;
				ctrl.pcwrite = 1'b1;
			end
			mips_pkg::s_decode: begin
				// precompute branch target into aluout
				ctrl.alusrcb = mips_pkg::b_imm_shifted;
			end
			mips_pkg::s_mem_addr, mips_pkg::s_addi_execute: begin
				// a + sign-extended immediate
				ctrl.alusrca = 1'b1;
				ctrl.alusrcb = mips_pkg::b_imm;
			end
			mips_pkg::s_mem_read: ctrl.iord = 1'b1;
			mips_pkg::s_mem_writeback: begin
				ctrl.memtoreg = 1'b1;
				ctrl.regwrite = 1'b1;
			end
			mips_pkg::s_mem_write: begin
				ctrl.iord     = 1'b1;
				ctrl.memwrite = 1'b1;
			end
			mips_pkg::s_execute: begin
				ctrl.alusrca = 1'b1;
				ctrl.aluop   = mips_pkg::aluop_funct;
			end
			mips_pkg::s_alu_writeback: begin
				// rd is the destination for r-type
				ctrl.regdst   = 1'b1;
				ctrl.regwrite = 1'b1;
			end
			mips_pkg::s_branch: begin
				// compare a and b, target already in aluout
				ctrl.alusrca = 1'b1;
				ctrl.pcsrc   = mips_pkg::pc_from_aluout;
				ctrl.aluop   = mips_pkg::aluop_sub;
				ctrl.branch  = 1'b1;
			end
			mips_pkg::s_addi_writeback: ctrl.regwrite = 1'b1;
			mips_pkg::s_jump: begin
				ctrl.pcsrc   = mips_pkg::pc_from_jump;
				ctrl.pcwrite = 1'b1;
			end
			default: ctrl = '0;
		endcase
	end

	// a store strobe only comes right after its address cycle
	store_after_addr: assert property (@(posedge clk) disable iff (reset)
		ctrl.memwrite |-> (state == mips_pkg::s_mem_write) &&
			($past(state) == mips_pkg::s_mem_addr));

	// state stays inside the encoded set
	state_legal: assert property (@(posedge clk) disable iff (reset)
		state inside {[mips_pkg::s_fetch:mips_pkg::s_jump]});

endmodule

/* controller.sv */
module controller (
	input  logic                clk,
	input  logic                reset,
	input  mips_pkg::opcode_e   op,
	input  mips_pkg::funct_e    funct,
	input  logic                zero,
	output mips_pkg::ctrl_t     ctrl,
	output mips_pkg::alu_ctrl_e alu_ctrl,
	output logic                pc_en,
	output mips_pkg::state_e    state
);

	// sequencing and the control word
	main_decoder main_decoder_i (
		.clk   (clk),
		.reset (reset),
		.op    (op),
		.ctrl  (ctrl),
		.state (state)
	);

	// alu decoding from aluop, then funct for r-type
	always_comb begin
		alu_ctrl = mips_pkg::alu_add;
		case (ctrl.aluop)
			mips_pkg::aluop_add: alu_ctrl = mips_pkg::alu_add;
			mips_pkg::aluop_sub: alu_ctrl = mips_pkg::alu_sub;
			mips_pkg::aluop_funct: begin
				case (funct)
					mips_pkg::fn_add: alu_ctrl = mips_pkg::alu_add;
					mips_pkg::fn_sub: alu_ctrl = mips_pkg::alu_sub;
					mips_pkg::fn_and: alu_ctrl = mips_pkg::alu_and;
					mips_pkg::fn_or:  alu_ctrl = mips_pkg::alu_or;
					mips_pkg::fn_slt: alu_ctrl = mips_pkg::alu_slt;
					// unsupported funct falls back to add
					default:          alu_ctrl = mips_pkg::alu_add;
				endcase
			end
			default: alu_ctrl = mips_pkg::alu_add;
		endcase
	end

	// unconditional pc write, or taken beq
	assign pc_en = ctrl.pcwrite | (ctrl.branch & zero);

endmodule

/* datapath.sv */
module datapath (
	input  logic                               clk,
	input  logic                               reset,
	input  mips_pkg::ctrl_t                    ctrl,
	input  mips_pkg::alu_ctrl_e                alu_ctrl,
	input  logic                               pc_en,
	input  logic [mips_pkg::word_bits-1:0]     mem_rdata,
	output mips_pkg::mem_req_t                 mem_req,
	output mips_pkg::opcode_e                  op,
	output mips_pkg::funct_e                   funct,
	output logic                               zero
);

	logic [mips_pkg::word_bits-1:0] pc;
	logic [mips_pkg::word_bits-1:0] pc_next;
	logic [mips_pkg::word_bits-1:0] instr;
	logic [mips_pkg::word_bits-1:0] data;
	logic [mips_pkg::word_bits-1:0] a;
	logic [mips_pkg::word_bits-1:0] b;
	logic [mips_pkg::word_bits-1:0] aluout;
	logic [mips_pkg::word_bits-1:0] rd1;
	logic [mips_pkg::word_bits-1:0] rd2;
	logic [mips_pkg::word_bits-1:0] src_a;
	logic [mips_pkg::word_bits-1:0] src_b;
	logic [mips_pkg::word_bits-1:0] alu_y;
	logic [mips_pkg::word_bits-1:0] sign_imm;
	logic [mips_pkg::word_bits-1:0] jump_target;
	logic [mips_pkg::word_bits-1:0] reg_wd;
	logic [4:0]                     reg_wa;

	// program counter, starts at the reset vector
	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			pc <= mips_pkg::reset_pc;
		end else if (pc_en) begin
			pc <= pc_next;
		end
	end

	// instruction latched on fetch only
	always_ff @(posedge clk) begin
		if (ctrl.irwrite) begin
			instr <= mem_rdata;
		end
	end

	// inter-cycle registers, loaded every cycle
	always_ff @(posedge clk) begin
		data   <= mem_rdata;
		a      <= rd1;
		b      <= rd2;
		aluout <= alu_y;
	end

	// instruction fields back to the controller
	assign op    = mips_pkg::opcode_e'(instr[31:26]);
	assign funct = mips_pkg::funct_e'(instr[5:0]);

	assign sign_imm    = {{16{instr[15]}}, instr[15:0]};
	// upper pc bits are from pc + 4, already updated
	assign jump_target = {pc[31:28], instr[25:0], 2'b00};

	// register write port, rd for r-type else rt
	assign reg_wa = ctrl.regdst ? instr[15:11] : instr[20:16];
	assign reg_wd = ctrl.memtoreg ? data : aluout;

	regfile regfile_i (
		.clk (clk),
		.ra1 (instr[25:21]),
		.ra2 (instr[20:16]),
		.wa  (reg_wa),
		.we  (ctrl.regwrite),
		.wd  (reg_wd),
		.rd1 (rd1),
		.rd2 (rd2)
	);

	// alu operands
	assign src_a = ctrl.alusrca ? a : pc;
	always_comb begin
		case (ctrl.alusrcb)
			mips_pkg::b_reg:         src_b = b;
			mips_pkg::b_four:        src_b = 32'd4;
			mips_pkg::b_imm:         src_b = sign_imm;
			mips_pkg::b_imm_shifted: src_b = {sign_imm[29:0], 2'b00};
			default:                 src_b = b;
		endcase
	end

	alu alu_i (
		.a    (src_a),
		.b    (src_b),
		.op   (alu_ctrl),
		.y    (alu_y),
		.zero (zero)
	);

	// next pc select
	always_comb begin
		case (ctrl.pcsrc)
			mips_pkg::pc_from_alu:    pc_next = alu_y;
			mips_pkg::pc_from_aluout: pc_next = aluout;
			mips_pkg::pc_from_jump:   pc_next = jump_target;
			default:                  pc_next = alu_y;
		endcase
	end

	// unified memory port, pc on fetch, aluout on data access
	assign mem_req.addr  = ctrl.iord ? aluout : pc;
	assign mem_req.wdata = b;
	assign mem_req.we    = ctrl.memwrite;

	// store address held in aluout must be word aligned
	store_aligned: assert property (@(posedge clk) disable iff (reset)
		mem_req.we |-> (mem_req.addr[1:0] == 2'b00));

endmodule

/* mips_multicycle.sv */
module mips_multicycle (
	input  logic                           clk,
	input  logic                           reset,
	input  logic [mips_pkg::word_bits-1:0] mem_rdata,
	output mips_pkg::mem_req_t             mem_req,
	output mips_pkg::state_e               state
);

	mips_pkg::ctrl_t     ctrl;
	mips_pkg::alu_ctrl_e alu_ctrl;
	mips_pkg::opcode_e   op;
	mips_pkg::funct_e    funct;
	logic                pc_en;
	logic                zero;

	// fsm, alu decoding and pc enable
	controller controller_i (
		.clk      (clk),
		.reset    (reset),
		.op       (op),
		.funct    (funct),
		.zero     (zero),
		.ctrl     (ctrl),
		.alu_ctrl (alu_ctrl),
		.pc_en    (pc_en),
		.state    (state)
	);

	// registers, muxes and the memory port
	datapath datapath_i (
		.clk       (clk),
		.reset     (reset),
		.ctrl      (ctrl),
		.alu_ctrl  (alu_ctrl),
		.pc_en     (pc_en),
		.mem_rdata (mem_rdata),
		.mem_req   (mem_req),
		.op        (op),
		.funct     (funct),
		.zero      (zero)
	);

endmodule

/* tb_program.svh */
`ifndef tb_program_svh
`define tb_program_svh

// program length in words, the last word is the halt loop
localparam int prog_len = 64;
localparam int halt_idx = prog_len - 1;
localparam logic [31:0] halt_addr = 32'(halt_idx * 4);
// data region, well above the code
localparam logic [31:0] data_base = 32'h0000_0800;
localparam int data_words = 64;

// initial memory contents, mixes every address bit
function automatic logic [31:0] fill_word(logic [31:0] addr);
	return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]} ^ 32'h5a5a_0f0f;
endfunction

function automatic logic [31:0] enc_imm(mips_pkg::opcode_e op, int rs, int rt, int imm);
	return {op, 5'(rs), 5'(rt), 16'(imm)};
endfunction

function automatic logic [31:0] enc_reg(mips_pkg::funct_e fn, int rs, int rt, int rd);
	return {6'b000000, 5'(rs), 5'(rt), 5'(rd), 5'b00000, fn};
endfunction

// word index of the target goes straight into the 26-bit field
function automatic logic [31:0] enc_jump(int idx);
	return {mips_pkg::op_j, 26'(idx)};
endfunction

function automatic mips_pkg::funct_e pick_funct(int n);
	case (n)
		0: return mips_pkg::fn_add;
		1: return mips_pkg::fn_sub;
		2: return mips_pkg::fn_and;
		3: return mips_pkg::fn_or;
		default: return mips_pkg::fn_slt;
	endcase
endfunction

task automatic build_program();
	int kind;
	int rs;
	int rt;
	int rd;
	int off;
	for (int k = 0; k < mem_words; k++) begin
		image[k] = fill_word(32'(k * 4));
	end
	// r7 is the data base, r1..r6 get known values
	image[0] = enc_imm(mips_pkg::op_addi, 0, 7, int'(data_base));
	for (int k = 1; k < 7; k++) begin
		image[k] = enc_imm(mips_pkg::op_addi, 0, k, int'($urandom % 200) - 100);
	end
	for (int k = 7; k < halt_idx; k++) begin
		kind = $urandom % 10;
		rs = $urandom % 8;
		rt = $urandom % 8;
		// destinations never touch r7, r0 is allowed
		rd = $urandom % 7;
		case (kind)
			0, 1: image[k] = enc_reg(pick_funct($urandom % 5), rs, rt, rd);
			2: image[k] = enc_imm(mips_pkg::op_lw, 7, rd, 4 * int'($urandom % data_words));
			3, 4: image[k] = enc_imm(mips_pkg::op_sw, 7, rt, 4 * int'($urandom % data_words));
			5: begin
				// forward only, never past the halt
				off = $urandom % 3;
				if (k + 1 + off > halt_idx) begin
					off = halt_idx - k - 1;
				end
				image[k] = enc_imm(mips_pkg::op_beq, rs, rt, off);
			end
			6, 9: image[k] = enc_imm(mips_pkg::op_addi, rs, rd, int'($urandom % 64) - 32);
			7: begin
				off = k + 1 + int'($urandom % 3);
				if (off > halt_idx) begin
					off = halt_idx;
				end
				image[k] = enc_jump(off);
			end
			// opcodes 0x30..0x37 are outside the subset
			default: image[k] = {6'(48 + int'($urandom % 8)), 26'($urandom)};
		endcase
	end
	image[halt_idx] = enc_jump(halt_idx);
endtask

function automatic logic [31:0] r_type_result(logic [5:0] fn, logic [31:0] a, logic [31:0] b);
	case (mips_pkg::funct_e'(fn))
		mips_pkg::fn_sub: return a - b;
		mips_pkg::fn_and: return a & b;
		mips_pkg::fn_or:  return a | b;
		mips_pkg::fn_slt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		default:          return a + b;
	endcase
endfunction

task automatic write_reg(logic [4:0] r, logic [31:0] v);
	if (r != 5'd0) begin
		ref_regs[r] = v;
	end
endtask

// instruction-level model, also lays out the expected state trace per class
task automatic run_reference();
	logic [31:0] pc;
	logic [31:0] instr;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] imm;
	logic [31:0] addr;
	mips_pkg::mem_req_t st;
	int halts;
	int steps;
	pc = '0;
	halts = 0;
	steps = 0;
	for (int k = 0; k < mem_words; k++) begin
		ref_mem[k] = image[k];
	end
	for (int r = 0; r < 32; r++) begin
		ref_regs[r] = '0;
	end
	// halt is executed twice, matching the end of the run
	while (halts < 2 && steps < 1000) begin
		instr = ref_mem[pc[11:2]];
		a = ref_regs[instr[25:21]];
		b = ref_regs[instr[20:16]];
		imm = {{16{instr[15]}}, instr[15:0]};
		addr = a + imm;
		exp_fetches.push_back(pc);
		exp_states.push_back(mips_pkg::s_fetch);
		exp_states.push_back(mips_pkg::s_decode);
		if (pc == halt_addr) begin
			halts++;
		end
		pc = pc + 32'd4;
		case (mips_pkg::opcode_e'(instr[31:26]))
			mips_pkg::op_rtype: begin
				exp_states.push_back(mips_pkg::s_execute);
				exp_states.push_back(mips_pkg::s_alu_writeback);
				write_reg(instr[15:11], r_type_result(instr[5:0], a, b));
			end
			mips_pkg::op_lw: begin
				exp_states.push_back(mips_pkg::s_mem_addr);
				exp_states.push_back(mips_pkg::s_mem_read);
				exp_states.push_back(mips_pkg::s_mem_writeback);
				write_reg(instr[20:16], ref_mem[addr[11:2]]);
			end
			mips_pkg::op_sw: begin
				exp_states.push_back(mips_pkg::s_mem_addr);
				exp_states.push_back(mips_pkg::s_mem_write);
				st.addr = addr;
				st.wdata = b;
				st.we = 1'b1;
				exp_stores.push_back(st);
				ref_mem[addr[11:2]] = b;
			end
			mips_pkg::op_beq: begin
				exp_states.push_back(mips_pkg::s_branch);
				if (a == b) begin
					pc = pc + (imm << 2);
				end
			end
			mips_pkg::op_addi: begin
				exp_states.push_back(mips_pkg::s_addi_execute);
				exp_states.push_back(mips_pkg::s_addi_writeback);
				write_reg(instr[20:16], a + imm);
			end
			mips_pkg::op_j: begin
				exp_states.push_back(mips_pkg::s_jump);
				pc = {pc[31:28], instr[25:0], 2'b00};
			end
			// unknown opcode, back to fetch after decode
			default: ;
		endcase
		steps++;
	end
endtask

`endif

/* tb_mips.sv */
module tb_mips;

	// 4 KB of word memory, code at zero and data at 0x800
	localparam int mem_words = 1024;
	localparam int timeout_cycles = 2000;

	logic                           clk;
	logic                           reset;
	logic [mips_pkg::word_bits-1:0] mem_rdata;
	mips_pkg::mem_req_t             mem_req;
	mips_pkg::state_e               state;

	logic [mips_pkg::word_bits-1:0] mem [mem_words];
	logic [mips_pkg::word_bits-1:0] image [mem_words];
	logic [mips_pkg::word_bits-1:0] ref_mem [mem_words];
	logic [mips_pkg::word_bits-1:0] ref_regs [32];
	mips_pkg::mem_req_t             write_req;
	logic [mips_pkg::word_bits-1:0] exp_fetches [$];
	mips_pkg::mem_req_t             exp_stores [$];
	mips_pkg::state_e               exp_states [$];
	int                             state_idx = 0;
	int                             fetch_idx = 0;
	int                             store_idx = 0;
	int                             halt_fetches = 0;
	int                             cycles;

	`include "tb_program.svh"

	mips_multicycle mips_multicycle_i (
		.clk       (clk),
		.reset     (reset),
		.mem_rdata (mem_rdata),
		.mem_req   (mem_req),
		.state     (state)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// reads answer in the same cycle
	assign mem_rdata = mem[mem_req.addr[11:2]];

	// write request taken mid-cycle, committed on the next rising edge
	always @(negedge clk) begin
		if (reset) begin
			write_req <= '0;
		end else begin
			write_req <= mem_req;
		end
	end

	// program image loads while reset is held
	always @(posedge clk) begin
		if (reset) begin
			for (int k = 0; k < mem_words; k++) begin
				mem[k] <= image[k];
			end
		end else if (write_req.we) begin
			mem[write_req.addr[11:2]] <= write_req.wdata;
		end
	end

	task automatic abort_run();
		$display("TEST FAIL");
		$fatal(1, "stopped at the first failure");
	endtask

	task automatic check_fetch(mips_pkg::mem_req_t exp, mips_pkg::mem_req_t act);
		if (act.addr !== exp.addr || act.we !== exp.we) begin
			$display("error at %0t: fetch expected addr %h we %b, got addr %h we %b",
				$time, exp.addr, exp.we, act.addr, act.we);
			abort_run();
		end
	endtask

	task automatic check_store(mips_pkg::mem_req_t exp, mips_pkg::mem_req_t act);
		if (act !== exp) begin
			$display("error at %0t: store expected addr %h data %h, got addr %h data %h",
				$time, exp.addr, exp.wdata, act.addr, act.wdata);
			abort_run();
		end
	endtask

	task automatic check_state(mips_pkg::state_e exp, mips_pkg::state_e act);
		if (act !== exp) begin
			$display("error at %0t: state expected %s, got %s", $time, exp.name(), act.name());
			abort_run();
		end
	endtask

	task automatic check_word(logic [31:0] addr, logic [31:0] exp, logic [31:0] act);
		if (act !== exp) begin
			$display("error at %0t: memory word %h expected %h, got %h", $time, addr, exp, act);
			abort_run();
		end
	endtask

	task automatic compare_data_region();
		logic [31:0] addr;
		for (int n = 0; n < data_words; n++) begin
			addr = data_base + 32'(n * 4);
			check_word(addr, ref_mem[addr[11:2]], mem[addr[11:2]]);
		end
	endtask

	// mid-cycle sampling of state, fetches and stores
	always @(negedge clk) begin : bus_monitor
		mips_pkg::mem_req_t fetch_exp;
		if (!reset) begin
			if (state_idx >= exp_states.size()) begin
				$display("the DUT ran past the end of the reference state trace");
				abort_run();
			end else begin
				// per-class cycle counts follow from the state trace
				check_state(exp_states[state_idx], state);
				state_idx++;
			end
			if (state == mips_pkg::s_fetch) begin
				// fetch data is not driven, only address and strobe matter
				fetch_exp.addr = exp_fetches[fetch_idx];
				fetch_exp.wdata = '0;
				fetch_exp.we = 1'b0;
				check_fetch(fetch_exp, mem_req);
				fetch_idx++;
				if (mem_req.addr == halt_addr) begin
					halt_fetches++;
				end
			end
			if (mem_req.we) begin
				if (store_idx >= exp_stores.size()) begin
					$display("the DUT issued a store that the reference program never makes");
					abort_run();
				end else begin
					check_store(exp_stores[store_idx], mem_req);
					store_idx++;
				end
			end
		end
	end

	initial begin
		void'($urandom(32'h54d3));
		reset = 1'b1;
		build_program();
		run_reference();
		repeat (5) @(posedge clk);
		#1 reset = 1'b0;
		cycles = 0;
		// run until the halt loop has been fetched twice
		while (halt_fetches < 2 && cycles < timeout_cycles) begin
			@(posedge clk);
			cycles++;
		end
		if (halt_fetches < 2) begin
			$display("the processor never reached the halt loop within %0d cycles",
				timeout_cycles);
			abort_run();
		end else if (store_idx != exp_stores.size()) begin
			$display("%0d stores of the reference program never reached the bus",
				exp_stores.size() - store_idx);
			abort_run();
		end else begin
			compare_data_region();
			$display("TEST PASS");
			$finish;
		end
	end

endmodule

/* tb.f */
+incdir+.
mips_pkg.sv
alu.sv
regfile.sv
main_decoder.sv
controller.sv
datapath.sv
mips_multicycle.sv
tb_mips.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_mips -f tb.f -o tb_mips_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/tb_mips_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST PASS"; then
	exit 0
fi
exit 1
